//--- test/dm_display_input.txt
# name glyph colour(0 off,1 green,2 red,3 amber) blank mode(0 normal,1 no credit,2 burst)
# then red rows 0..7 and green rows 0..7 in hex, row 0 first
level0_green   0 1 0 0 00 00 00 00 00 00 00 00 00 00 00 18 18 00 00 00
level1_green   1 1 0 0 00 00 00 00 00 00 00 00 00 00 18 3c 3c 18 00 00
level2_green   2 1 0 0 00 00 00 00 00 00 00 00 00 00 3c 3c 3c 3c 00 00
level3_green   3 1 0 0 00 00 00 00 00 00 00 00 00 3c 7e 7e 7e 7e 3c 00
level4_green   4 1 0 0 00 00 00 00 00 00 00 00 00 7e 7e 7e 7e 7e 7e 00
level5_green   5 1 0 0 00 00 00 00 00 00 00 00 ff ff ff ff ff ff ff ff
flame_red      6 2 0 0 10 18 38 3c 7e 6e 66 3c 00 00 00 00 00 00 00 00
flame_green    6 1 0 0 00 00 00 00 00 00 00 00 10 18 38 3c 7e 6e 66 3c
flame_amber    6 3 0 0 10 18 38 3c 7e 6e 66 3c 10 18 38 3c 7e 6e 66 3c
flame_off      6 0 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
face_amber     8 3 0 0 3c 42 a5 81 a5 99 42 3c 3c 42 a5 81 a5 99 42 3c
note_red      11 2 0 0 0c 0e 0b 09 08 78 f8 70 00 00 00 00 00 00 00 00
cloud_green    9 1 0 0 00 00 00 00 00 00 00 00 00 00 30 7c fe ff 7e 00
drop_red       7 2 0 0 18 18 3c 7e 7e 7e 3c 00 00 00 00 00 00 00 00 00
face_blank     8 1 1 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
bell_amber    10 3 0 0 18 3c 3c 7e 7e ff 00 18 18 3c 3c 7e 7e ff 00 18
bell_blank    10 3 1 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
empty_glyph   13 1 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
level5_amber   5 3 0 0 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
burst_drop     7 1 0 2 00 00 00 00 00 00 00 00 18 18 3c 7e 7e 7e 3c 00
burst_note    11 3 0 2 0c 0e 0b 09 08 78 f8 70 0c 0e 0b 09 08 78 f8 70
burst_cloud    9 2 0 2 00 00 30 7c fe ff 7e 00 00 00 00 00 00 00 00 00
burst_level3   3 3 0 2 00 3c 7e 7e 7e 7e 3c 00 00 3c 7e 7e 7e 7e 3c 00
# the dropped face must not show, the previous level3 stays
no_credit      8 3 0 1 00 3c 7e 7e 7e 7e 3c 00 00 3c 7e 7e 7e 7e 3c 00
bell_green    10 1 0 0 00 00 00 00 00 00 00 00 18 3c 3c 7e 7e ff 00 18

//--- all.f
rtl/dm_panel_pkg.sv
rtl/dm_cmd_pkg.sv
rtl/dm_cmd_rx.sv
rtl/dm_glyph_rom.sv
rtl/dm_frame_builder.sv
rtl/dm_row_scanner.sv
rtl/dm_display_top.sv
test/dm_display_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing -f all.f --top-module dm_display_tb --Mdir obj_dir -o dm_display_sim
	./obj_dir/dm_display_sim > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/dm_display_tb.sv
`timescale 1ns/10ps

module dm_display_tb;
    import dm_panel_pkg::*;
    import dm_cmd_pkg::*;

    localparam int FIFO_DEPTH = 4;
    localparam int SCAN_DIV   = 16;
    localparam int MAX_TESTS  = 64;

    logic      clk;
    logic      rst;
    logic      cmd_valid;
    disp_cmd_t cmd;
    logic      credit_ret;
    logic      overflow;
    col_t      row_sel;
    col_t      col_red;
    col_t      col_green;

    string      names [MAX_TESTS];
    disp_cmd_t  cmds [MAX_TESTS];
    int         modes [MAX_TESTS];  // 0 normal, 1 break credit rule, 2 burst
    col_t [7:0] exp_red [MAX_TESTS];
    col_t [7:0] exp_green [MAX_TESTS];

    int     n_tests  = 0;
    int     n_pass   = 0;
    int     n_fail   = 0;
    int     errors   = 0;
    int     sent     = 0;
    int     returned = 0;
    bit     loaded   = 1'b0;
    integer seed     = 32'h63a6_6310;

    dm_display_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .SCAN_DIV   (SCAN_DIV)
    ) dm_display_top_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .credit_ret (credit_ret),
        .overflow   (overflow),
        .row_sel    (row_sel),
        .col_red    (col_red),
        .col_green  (col_green)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // credits come back one per high cycle
    always @(negedge clk)
    begin
        if (!rst && credit_ret)
            returned++;
    end

    function automatic int credits();
        return FIFO_DEPTH - sent + returned;
    endfunction

    task automatic load_tests();
        int    fd;
        int    g;
        int    c;
        int    b;
        int    m;
        string line;
        string name;
        col_t  r [8];
        col_t  gr [8];
        fd = $fopen("test/dm_display_input.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the stimulus file test/dm_display_input.txt");
            n_fail++;
            return;
        end
        while (n_tests < MAX_TESTS && $fgets(line, fd) != 0)
        begin
            if (line.len() < 3 || line[0] == 8'h23)
                continue;  // comment or empty
            if ($sscanf(line, "%s %d %d %d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        name, g, c, b, m, r[0], r[1], r[2], r[3], r[4], r[5], r[6], r[7],
                        gr[0], gr[1], gr[2], gr[3], gr[4], gr[5], gr[6], gr[7]) != 21)
            begin
                $display("a line of the stimulus file does not have 21 fields");
                n_fail++;
                continue;
            end
            names[n_tests]       = name;
            cmds[n_tests].glyph  = glyph_id_t'(g);
            cmds[n_tests].color  = color_e'(c);
            cmds[n_tests].blank  = (b != 0);
            modes[n_tests]       = m;
            for (int i = 0; i < 8; i++)
            begin
                exp_red[n_tests][i]   = r[i];
                exp_green[n_tests][i] = gr[i];
            end
            n_tests++;
        end
        $fclose(fd);
        if (n_tests == 0)
        begin
            $display("the stimulus file holds no tests");
            n_fail++;
        end
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_cmd(input disp_cmd_t c);
        cmd_valid = 1'b1;
        cmd       = c;
        sent++;
        @(posedge clk);
        #1 cmd_valid = 1'b0;
    endtask

    task automatic wait_credit();
        while (credits() == 0)
            idle(1);
    endtask

    task automatic wait_returns();
        while (returned < sent)
            @(negedge clk);
    endtask

    // next change of row_sel to the row 0 pattern
    task automatic wait_row0();
        col_t prev;
        prev = row_sel;
        @(negedge clk);
        while (!(row_sel == 8'hfe && prev != 8'hfe))
        begin
            prev = row_sel;
            @(negedge clk);
        end
    endtask

    task automatic grab_frame(input string name, output col_t [7:0] fr, output col_t [7:0] fg);
        col_t prev;
        wait_row0();
        fr[0] = col_red;
        fg[0] = col_green;
        for (int r = 1; r < 8; r++)
        begin
            prev = row_sel;
            while (row_sel == prev)
                @(negedge clk);
            check_value(name, $sformatf("row %0d select", r), ~(col_t'(1) << r), row_sel);
            fr[r] = col_red;
            fg[r] = col_green;
        end
    endtask

    task automatic check_value(input string name, input string what,
                               input col_t exp, input col_t act);
        if (exp !== act)
        begin
            $display("mismatch %s %s: expected %h actual %h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_frame(input int t, input col_t [7:0] fr, input col_t [7:0] fg);
        for (int r = 0; r < 8; r++)
        begin
            check_value(names[t], $sformatf("row %0d red", r), exp_red[t][r], fr[r]);
            check_value(names[t], $sformatf("row %0d green", r), exp_green[t][r], fg[r]);
        end
    endtask

    task automatic finish_test(input int t);
        if (errors == 0)
        begin
            n_pass++;
            $display("test %s ok", names[t]);
        end
        else
        begin
            n_fail++;
            $display("test %s failed with %0d errors", names[t], errors);
        end
    endtask

    task automatic run_single(input int t);
        col_t [7:0] fr;
        col_t [7:0] fg;
        errors = 0;
        idle(1);  // back onto the drive point
        wait_credit();
        idle($random(seed) & 3);
        send_cmd(cmds[t]);
        wait_returns();
        wait_row0();
        grab_frame(names[t], fr, fg);
        check_frame(t, fr, fg);
        check_value(names[t], "credits", col_t'(FIFO_DEPTH), col_t'(credits()));
        finish_test(t);
    endtask

    // each burst command is on the panel for one frame, in order
    task automatic run_burst(input int first, input int last);
        col_t [7:0] fr;
        col_t [7:0] fg;
        int         tries;
        errors = 0;
        fork
            begin
                idle(1);  // back onto the drive point
                for (int i = first; i <= last; i++)
                begin
                    wait_credit();
                    send_cmd(cmds[i]);
                    idle($random(seed) & 3);
                end
            end
            begin
                // first swap can land one frame late
                grab_frame(names[first], fr, fg);
                tries = 1;
                while (tries < 3 && (fr != exp_red[first] || fg != exp_green[first]))
                begin
                    grab_frame(names[first], fr, fg);
                    tries++;
                end
                check_frame(first, fr, fg);
                for (int i = first + 1; i <= last; i++)
                begin
                    finish_test(i - 1);
                    errors = 0;
                    grab_frame(names[i], fr, fg);
                    check_frame(i, fr, fg);
                end
            end
        join
        wait_returns();
        check_value(names[last], "overflow", 8'h00, col_t'(overflow));
        check_value(names[last], "credits", col_t'(FIFO_DEPTH), col_t'(credits()));
        finish_test(last);
    endtask

    task automatic run_overflow(input int t, input disp_cmd_t prev);
        col_t [7:0] fr;
        col_t [7:0] fg;
        errors = 0;
        idle(1);  // back onto the drive point
        while (credits() > 0)
            send_cmd(prev);  // repeats keep the old glyph up
        cmd_valid = 1'b1;  // no credit left, dropped
        cmd       = cmds[t];
        @(posedge clk);
        #1 cmd_valid = 1'b0;
        @(negedge clk);
        check_value(names[t], "overflow", 8'h01, col_t'(overflow));
        wait_returns();
        wait_row0();
        grab_frame(names[t], fr, fg);
        check_frame(t, fr, fg);
        check_value(names[t], "credits", col_t'(FIFO_DEPTH), col_t'(credits()));
        finish_test(t);
    endtask

    initial
    begin
        wait (loaded);
        #((longint'(n_tests) + 1) * (3 * 8 * SCAN_DIV + 100) * 10);
        $display("timeout: the tests did not finish in the allowed time");
        $display("tests failed");
        $finish;
    end

    initial
    begin
        disp_cmd_t prev_cmd;
        int        t;
        int        last;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        load_tests();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        prev_cmd = '0;
        t = 0;
        while (t < n_tests)
        begin
            if (modes[t] == 2)
            begin
                last = t;
                while (last + 1 < n_tests && modes[last + 1] == 2)
                    last++;
                run_burst(t, last);
                prev_cmd = cmds[last];
                t = last + 1;
            end
            else if (modes[t] == 1)
            begin
                run_overflow(t, prev_cmd);
                t++;
            end
            else
            begin
                run_single(t);
                prev_cmd = cmds[t];
                t++;
            end
        end
        $display("passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- rtl/dm_display_top.sv
`timescale 1ns/10ps

module dm_display_top #(
    parameter int FIFO_DEPTH = 4,
    parameter int SCAN_DIV   = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    input  dm_cmd_pkg::disp_cmd_t cmd,
    output logic                  credit_ret,
    output logic                  overflow,
    output dm_panel_pkg::col_t    row_sel,
    output dm_panel_pkg::col_t    col_red,
    output dm_panel_pkg::col_t    col_green
);
    import dm_panel_pkg::*;
    import dm_cmd_pkg::*;

    logic      q_valid;
    disp_cmd_t q_cmd;
    logic      q_pop;
    glyph_id_t rom_glyph;
    row_idx_t  rom_row;
    col_t      rom_bits;
    frame_t    front;
    logic      frame_start;

    dm_cmd_rx #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dm_cmd_rx_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .credit_ret (credit_ret),
        .overflow   (overflow),
        .q_valid    (q_valid),
        .q_cmd      (q_cmd),
        .q_pop      (q_pop)
    );

    dm_frame_builder dm_frame_builder_i (
        .clk         (clk),
        .rst         (rst),
        .q_valid     (q_valid),
        .q_cmd       (q_cmd),
        .q_pop       (q_pop),
        .rom_glyph   (rom_glyph),
        .rom_row     (rom_row),
        .rom_bits    (rom_bits),
        .frame_start (frame_start),
        .front       (front)
    );

    dm_glyph_rom dm_glyph_rom_i (
        .clk       (clk),
        .rom_glyph (rom_glyph),
        .rom_row   (rom_row),
        .rom_bits  (rom_bits)
    );

    dm_row_scanner #(
        .SCAN_DIV (SCAN_DIV)
    ) dm_row_scanner_i (
        .clk         (clk),
        .rst         (rst),
        .front       (front),
        .row_sel     (row_sel),
        .col_red     (col_red),
        .col_green   (col_green),
        .frame_start (frame_start)
    );

endmodule

//--- rtl/dm_row_scanner.sv
`timescale 1ns/10ps

module dm_row_scanner #(
    parameter int SCAN_DIV = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  dm_panel_pkg::frame_t front,
    output dm_panel_pkg::col_t   row_sel,
    output dm_panel_pkg::col_t   col_red,
    output dm_panel_pkg::col_t   col_green,
    output logic                 frame_start
);
    import dm_panel_pkg::*;

    localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [DIV_W-1:0] dwell;
    row_idx_t         row_cnt;
    logic             row_adv;
    logic             row_load;

    assign row_adv     = (dwell == DIV_W'(SCAN_DIV - 1));
    assign frame_start = row_adv && (row_cnt == row_idx_t'(ROWS - 1));  // 7 -> 0

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dwell     <= '0;
            row_cnt   <= '0;
            row_load  <= 1'b0;
            row_sel   <= '1;  // all rows off
            col_red   <= '0;
            col_green <= '0;
        end
        else
        begin
            if (row_adv)
            begin
                dwell   <= '0;
                row_cnt <= row_cnt + 1'b1;
            end
            else
            begin
                dwell <= dwell + 1'b1;
            end

            // load one cycle later so a swap at the wrap is already in front
            row_load <= row_adv;
            if (row_load)
            begin
                row_sel   <= ~(col_t'(1) << row_cnt);
                col_red   <= front.red[row_cnt];
                col_green <= front.green[row_cnt];
            end
        end
    end

endmodule

//--- rtl/dm_frame_builder.sv
`timescale 1ns/10ps

module dm_frame_builder (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   q_valid,
    input  dm_cmd_pkg::disp_cmd_t  q_cmd,
    output logic                   q_pop,
    output dm_cmd_pkg::glyph_id_t  rom_glyph,
    output dm_panel_pkg::row_idx_t rom_row,
    input  dm_panel_pkg::col_t     rom_bits,
    input  logic                   frame_start,
    output dm_panel_pkg::frame_t   front
);
    import dm_panel_pkg::*;
    import dm_cmd_pkg::*;

    // step runs 0..ROWS, rom data trails the address by one
    localparam logic [3:0] FETCH_LAST = 4'(ROWS);

    typedef enum logic [1:0]
    {
        st_idle,
        st_fetch,
        st_ready
    } state_t;

    state_t     state;
    disp_cmd_t  cmd_r;
    logic [3:0] step;
    frame_t     back;
    row_idx_t   wr_row;
    logic       wr_en;
    logic       red_en;
    logic       green_en;

    // pop only while the back buffer is free
    assign q_pop = (state == st_idle) && q_valid;

    assign rom_glyph = cmd_r.glyph;
    assign rom_row   = row_idx_t'(step);

    assign wr_en  = (state == st_fetch) && (step != 4'd0);
    assign wr_row = row_idx_t'(step - 4'd1);

    assign red_en   = !cmd_r.blank &&
                      (cmd_r.color == color_red || cmd_r.color == color_amber);
    assign green_en = !cmd_r.blank &&
                      (cmd_r.color == color_green || cmd_r.color == color_amber);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= st_idle;
            step  <= 4'd0;
            front <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                    if (q_pop)
                    begin
                        state <= st_fetch;
                        step  <= 4'd0;
                    end
                st_fetch:
                begin
                    step <= step + 4'd1;
                    if (step == FETCH_LAST)  // last row lands this cycle
                        state <= st_ready;
                end
                st_ready:
                    // swap only on the frame boundary, no tearing
                    if (frame_start)
                    begin
                        front <= back;
                        state <= st_idle;
                    end
                default:
                    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (q_pop)
            cmd_r <= q_cmd;

        // every row rewritten, so nothing stale survives
        if (wr_en)
        begin
            back.red[wr_row]   <= red_en ? rom_bits : '0;
            back.green[wr_row] <= green_en ? rom_bits : '0;
        end
    end

endmodule

//--- rtl/dm_glyph_rom.sv
`timescale 1ns/10ps

module dm_glyph_rom (
    input  logic                   clk,
    input  dm_cmd_pkg::glyph_id_t  rom_glyph,
    input  dm_panel_pkg::row_idx_t rom_row,
    output dm_panel_pkg::col_t     rom_bits
);

    always_ff @(posedge clk)
    begin
        rom_bits <= 8'b0000_0000;  // unlisted rows and glyphs
        case (rom_glyph)
            // level bars, each one nests the previous
            4'd0:
                case (rom_row)
                    3'd3, 3'd4: rom_bits <= 8'b0001_1000;
                    default:    rom_bits <= 8'b0000_0000;
                endcase
            4'd1:
                case (rom_row)
                    3'd2, 3'd5: rom_bits <= 8'b0001_1000;
                    3'd3, 3'd4: rom_bits <= 8'b0011_1100;
                    default:    rom_bits <= 8'b0000_0000;
                endcase
            4'd2:
                case (rom_row)
                    3'd2, 3'd3, 3'd4, 3'd5: rom_bits <= 8'b0011_1100;
                    default:                rom_bits <= 8'b0000_0000;
                endcase
            4'd3:
                case (rom_row)
                    3'd1, 3'd6:             rom_bits <= 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: rom_bits <= 8'b0111_1110;
                    default:                rom_bits <= 8'b0000_0000;
                endcase
            4'd4:
                case (rom_row)
                    3'd0, 3'd7: rom_bits <= 8'b0000_0000;
                    default:    rom_bits <= 8'b0111_1110;
                endcase
            4'd5:
                rom_bits <= 8'b1111_1111;  // full panel
            4'd6:
                case (rom_row)  // flame
                    3'd0: rom_bits <= 8'b0001_0000;
                    3'd1: rom_bits <= 8'b0001_1000;
                    3'd2: rom_bits <= 8'b0011_1000;
                    3'd3: rom_bits <= 8'b0011_1100;
                    3'd4: rom_bits <= 8'b0111_1110;
                    3'd5: rom_bits <= 8'b0110_1110;
                    3'd6: rom_bits <= 8'b0110_0110;
                    3'd7: rom_bits <= 8'b0011_1100;
                endcase
            4'd7:
                case (rom_row)  // drop
                    3'd0, 3'd1:       rom_bits <= 8'b0001_1000;
                    3'd2, 3'd6:       rom_bits <= 8'b0011_1100;
                    3'd3, 3'd4, 3'd5: rom_bits <= 8'b0111_1110;
                    default:          rom_bits <= 8'b0000_0000;
                endcase
            4'd8:
                case (rom_row)  // face
                    3'd0, 3'd7: rom_bits <= 8'b0011_1100;
                    3'd1, 3'd6: rom_bits <= 8'b0100_0010;
                    3'd2, 3'd4: rom_bits <= 8'b1010_0101;
                    3'd3:       rom_bits <= 8'b1000_0001;
                    3'd5:       rom_bits <= 8'b1001_1001;
                endcase
            4'd9:
                case (rom_row)  // cloud
                    3'd2:    rom_bits <= 8'b0011_0000;
                    3'd3:    rom_bits <= 8'b0111_1100;
                    3'd4:    rom_bits <= 8'b1111_1110;
                    3'd5:    rom_bits <= 8'b1111_1111;
                    3'd6:    rom_bits <= 8'b0111_1110;
                    default: rom_bits <= 8'b0000_0000;
                endcase
            4'd10:
                case (rom_row)  // bell, clapper on the last row
                    3'd0, 3'd7: rom_bits <= 8'b0001_1000;
                    3'd1, 3'd2: rom_bits <= 8'b0011_1100;
                    3'd3, 3'd4: rom_bits <= 8'b0111_1110;
                    3'd5:       rom_bits <= 8'b1111_1111;
                    default:    rom_bits <= 8'b0000_0000;
                endcase
            4'd11:
                case (rom_row)  // note
                    3'd0: rom_bits <= 8'b0000_1100;
                    3'd1: rom_bits <= 8'b0000_1110;
                    3'd2: rom_bits <= 8'b0000_1011;
                    3'd3: rom_bits <= 8'b0000_1001;
                    3'd4: rom_bits <= 8'b0000_1000;
                    3'd5: rom_bits <= 8'b0111_1000;
                    3'd6: rom_bits <= 8'b1111_1000;
                    3'd7: rom_bits <= 8'b0111_0000;
                endcase
            default:
                rom_bits <= 8'b0000_0000;
        endcase
    end

endmodule

//--- rtl/dm_cmd_rx.sv
`timescale 1ns/10ps

module dm_cmd_rx #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    input  dm_cmd_pkg::disp_cmd_t cmd,
    output logic                  credit_ret,
    output logic                  overflow,
    output logic                  q_valid,
    output dm_cmd_pkg::disp_cmd_t q_cmd,
    input  logic                  q_pop
);
    import dm_cmd_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    disp_cmd_t        mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    // wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(FIFO_DEPTH - 1))
            return '0;
        return p + 1'b1;
    endfunction

    assign full    = (count == CNT_W'(FIFO_DEPTH));
    assign wr_en   = cmd_valid && !full;
    assign rd_en   = q_pop && q_valid;
    assign q_valid = (count != '0);
    assign q_cmd   = mem[rd_ptr];  // head of queue

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
            overflow   <= 1'b0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= ptr_inc(wr_ptr);
            if (rd_en)
                rd_ptr <= ptr_inc(rd_ptr);

            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // sender ignored the credit count
            if (cmd_valid && full)
                overflow <= 1'b1;

            credit_ret <= rd_en;  // one credit back per pop
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= cmd;
    end

endmodule

//--- rtl/dm_cmd_pkg.sv
package dm_cmd_pkg;

    // 0..11 defined, 12..15 read as empty
    typedef logic [3:0] glyph_id_t;

    // host display command, 7 bits
    typedef struct packed
    {
        glyph_id_t            glyph;
        dm_panel_pkg::color_e color;
        logic                 blank;  // clears both planes
    } disp_cmd_t;

endpackage

//--- rtl/dm_panel_pkg.sv
package dm_panel_pkg;

    // panel geometry
    localparam int ROWS = 8;
    localparam int COLS = 8;

    typedef logic [$clog2(ROWS)-1:0] row_idx_t;

    // bit 7 is the leftmost led
    typedef logic [COLS-1:0] col_t;

    // amber lights both planes
    typedef enum logic [1:0]
    {
        color_off   = 2'd0,
        color_green = 2'd1,
        color_red   = 2'd2,
        color_amber = 2'd3
    } color_e;

    // one complete two-colour frame, 128 bits
    typedef struct packed
    {
        col_t [ROWS-1:0] red;
        col_t [ROWS-1:0] green;
    } frame_t;

endpackage
